// ==== Makefile ====
SIM        = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = programMapperTb
FILELIST   = sim.f
BUILD_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim.f ====
verilog/progMapPkg.sv
verilog/slotEncoder.sv
verilog/usedSizeTracker.sv
verilog/mapTable.sv
verilog/mapControl.sv
verilog/programMapper.sv
tb/programMapperTb.sv

// ==== tb/programMapperTb.sv ====
// Directed rows at a fixed one-cycle ack latency; a plain store row must never start while full
module programMapperTb
	import progMapPkg::*;
();

	typedef enum logic [1:0] {
		opStore,
		opLookup,
		opBoth	// Store and lookup raised in the same cycle
	} stimOp_e;

	typedef struct packed {
		stimOp_e   op;
		threadId_t storeId;
		memWord_t  length;
		threadId_t lookupId;
		logic      expectFull;	// Level of full when the row starts
	} stimRow_t;

	localparam int ClockPeriod   = 40;
	localparam int ResetCycles   = 8;
	localparam int HoldCycles    = 4;	// Cycles a blocked store is held
	localparam int NumRows       = 32;
	localparam int TimeoutCycles = NumRows * 16 + ResetCycles;

	//////////////////////////////
	// Stimulus table
	//////////////////////////////

	localparam stimRow_t Rows [NumRows] = '{
		'{opStore,  6'd1,  10'd16,  6'd0,  1'b0},
		'{opStore,  6'd2,  10'd40,  6'd0,  1'b0},
		'{opStore,  6'd3,  10'd8,   6'd0,  1'b0},
		'{opLookup, 6'd0,  10'd0,   6'd2,  1'b0},	// Hit in the middle
		'{opLookup, 6'd0,  10'd0,   6'd2,  1'b0},	// Same ID again misses
		'{opLookup, 6'd0,  10'd0,   6'd33, 1'b0},
		'{opLookup, 6'd0,  10'd0,   6'd1,  1'b0},
		'{opLookup, 6'd0,  10'd0,   6'd3,  1'b0},
		'{opBoth,   6'd4,  10'd20,  6'd4,  1'b0},	// Lookup finds the fresh store
		'{opBoth,   6'd5,  10'd12,  6'd1,  1'b0},
		'{opStore,  6'd10, 10'd10,  6'd0,  1'b0},
		'{opStore,  6'd11, 10'd10,  6'd0,  1'b0},
		'{opStore,  6'd12, 10'd10,  6'd0,  1'b0},
		'{opStore,  6'd13, 10'd10,  6'd0,  1'b0},
		'{opStore,  6'd14, 10'd10,  6'd0,  1'b0},
		'{opStore,  6'd15, 10'd10,  6'd0,  1'b0},
		'{opStore,  6'd16, 10'd10,  6'd0,  1'b0},
		'{opBoth,   6'd20, 10'd5,   6'd5,  1'b1},	// Ninth store held until a slot frees
		'{opLookup, 6'd0,  10'd0,   6'd20, 1'b1},
		'{opLookup, 6'd0,  10'd0,   6'd10, 1'b0},
		'{opLookup, 6'd0,  10'd0,   6'd11, 1'b0},
		'{opLookup, 6'd0,  10'd0,   6'd12, 1'b0},
		'{opLookup, 6'd0,  10'd0,   6'd13, 1'b0},
		'{opLookup, 6'd0,  10'd0,   6'd14, 1'b0},
		'{opLookup, 6'd0,  10'd0,   6'd15, 1'b0},
		'{opLookup, 6'd0,  10'd0,   6'd16, 1'b0},
		'{opStore,  6'd40, 10'd600, 6'd0,  1'b0},
		'{opStore,  6'd41, 10'd423, 6'd0,  1'b0},	// Reaches the last word
		'{opBoth,   6'd43, 10'd100, 6'd40, 1'b1},	// Capacity hold
		'{opLookup, 6'd0,  10'd0,   6'd41, 1'b0},
		'{opLookup, 6'd0,  10'd0,   6'd43, 1'b0},
		'{opLookup, 6'd0,  10'd0,   6'd63, 1'b0}
	};

	logic          clock;
	logic          reset;
	logic          storeReq;
	storeRequest_t storeData;
	logic          storeAck;
	logic          lookupReq;
	threadId_t     lookupId;
	logic          lookupAck;
	lookupResult_t lookupResult;
	memWord_t      usedSize;
	logic          full;

	// Reference model state
	logic      mValid [TableEntries];
	threadId_t mId    [TableEntries];
	memWord_t  mAddr  [TableEntries];
	memWord_t  mLen   [TableEntries];
	memWord_t  mUsed;
	integer    seed;

	programMapper i_programMapper (
		.clock        (clock),
		.reset        (reset),
		.storeReq     (storeReq),
		.storeData    (storeData),
		.storeAck     (storeAck),
		.lookupReq    (lookupReq),
		.lookupId     (lookupId),
		.lookupAck    (lookupAck),
		.lookupResult (lookupResult),
		.usedSize     (usedSize),
		.full         (full)
	);

	always #(ClockPeriod / 2) clock = ~clock;

	//////////////////////////////
	// Reporting and compares
	//////////////////////////////

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkLookup(input lookupResult_t got, input lookupResult_t exp);
		if (got !== exp) begin
			abortRun($sformatf("FAILED lookupResult: got %h expected %h", got, exp));
		end
	endtask

	task automatic checkUsed(input memWord_t got, input memWord_t exp);
		if (got !== exp) begin
			abortRun($sformatf("FAILED usedSize: got %h expected %h", got, exp));
		end
	endtask

	task automatic checkFull(input logic got, input logic exp);
		if (got !== exp) begin
			abortRun($sformatf("FAILED full: got %h expected %h", got, exp));
		end
	endtask

	task automatic requireAck(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			abortRun(what);
		end
	endtask

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic modelFull();
		int busy;
		busy = 0;
		for (int i = 0; i < TableEntries; i++) begin
			if (mValid[i]) begin
				busy++;
			end
		end
		return (busy == TableEntries) || (mUsed >= memWord_t'(MemWords - 1));
	endfunction

	task automatic modelStore(input threadId_t id, input memWord_t len);
		int slot;
		slot = -1;
		for (int i = TableEntries - 1; i >= 0; i--) begin
			if (!mValid[i]) begin
				slot = i;	// Lowest free slot wins
			end
		end
		if (slot < 0) begin
			abortRun("reference model found no free slot for a store");
		end else begin
			mValid[slot] = 1'b1;
			mId[slot]    = id;
			mAddr[slot]  = mUsed;	// Start at the old used size
			mLen[slot]   = len;
			mUsed        = mUsed + len;
		end
	endtask

	task automatic modelLookup(input threadId_t id, output lookupResult_t res);
		int slot;
		slot = -1;
		res  = '0;
		for (int i = TableEntries - 1; i >= 0; i--) begin
			if (mValid[i] && mId[i] == id) begin
				slot = i;
			end
		end
		if (slot >= 0) begin
			res.hit      = 1'b1;
			res.address  = mAddr[slot];
			res.length   = mLen[slot];
			mValid[slot] = 1'b0;
			mUsed        = mUsed - mLen[slot];
		end
	endtask

	//////////////////////////////
	// Transactions
	//////////////////////////////

	// Each task starts and ends on a falling edge
	task automatic runStore(input threadId_t id, input memWord_t len);
		@(posedge clock);
		storeReq  <= 1'b1;
		storeData <= '{threadId: id, length: len};
		@(posedge clock);	// Request sampled here
		@(negedge clock);
		requireAck(storeAck, 1'b1, "store was not acknowledged one cycle after it was sampled");
		modelStore(id, len);
		checkUsed(usedSize, mUsed);
		@(posedge clock);
		storeReq <= 1'b0;
		@(negedge clock);
		requireAck(storeAck, 1'b0, "store acknowledge lasted longer than one cycle");
	endtask

	task automatic runLookup(input threadId_t id);
		lookupResult_t exp;
		@(posedge clock);
		lookupReq <= 1'b1;
		lookupId  <= id;
		@(posedge clock);
		@(negedge clock);
		requireAck(lookupAck, 1'b1, "lookup was not acknowledged one cycle after it was sampled");
		modelLookup(id, exp);
		checkLookup(lookupResult, exp);
		checkUsed(usedSize, mUsed);
		@(posedge clock);
		lookupReq <= 1'b0;
		@(negedge clock);
		requireAck(lookupAck, 1'b0, "lookup acknowledge lasted longer than one cycle");
	endtask

	// Both requests together with room left, so the store goes first
	task automatic runPair(input threadId_t sid, input memWord_t len, input threadId_t lid);
		@(posedge clock);
		storeReq  <= 1'b1;
		storeData <= '{threadId: sid, length: len};
		lookupReq <= 1'b1;
		lookupId  <= lid;
		@(posedge clock);
		@(negedge clock);
		requireAck(storeAck, 1'b1, "store of a paired request was not acknowledged first");
		requireAck(lookupAck, 1'b0, "lookup was acknowledged together with the store");
		modelStore(sid, len);
		checkUsed(usedSize, mUsed);
		@(posedge clock);
		storeReq <= 1'b0;
		@(negedge clock);
		requireAck(lookupAck, 1'b0, "lookup was acknowledged during the store's return to idle");
		runLookupTail(lid);
	endtask

	// Table or memory full, store held while a lookup frees room
	task automatic runHeldPair(input threadId_t sid, input memWord_t len, input threadId_t lid);
		@(posedge clock);
		storeReq  <= 1'b1;
		storeData <= '{threadId: sid, length: len};
		repeat (HoldCycles) begin
			@(negedge clock);
			requireAck(storeAck, 1'b0, "store was acknowledged while full was high");
			checkFull(full, 1'b1);
		end
		@(posedge clock);
		lookupReq <= 1'b1;
		lookupId  <= lid;
		@(posedge clock);
		@(negedge clock);
		requireAck(lookupAck, 1'b1, "lookup was not served while a store was held back");
		requireAck(storeAck, 1'b0, "held store was acknowledged before the lookup");
		runLookupChecks(lid);
		if (modelFull()) begin
			abortRun("stimulus table holds a store that the lookup cannot release");
		end else begin
			@(posedge clock);
			lookupReq <= 1'b0;
			@(posedge clock);
			@(negedge clock);
			requireAck(storeAck, 1'b1, "held store did not complete after full dropped");
			modelStore(sid, len);
			checkUsed(usedSize, mUsed);
			@(posedge clock);
			storeReq <= 1'b0;
			@(negedge clock);
		end
	endtask

	task automatic runLookupChecks(input threadId_t id);
		lookupResult_t exp;
		modelLookup(id, exp);
		checkLookup(lookupResult, exp);
		checkUsed(usedSize, mUsed);
	endtask

	// Lookup already requested, served on the next idle edge
	task automatic runLookupTail(input threadId_t id);
		@(posedge clock);
		@(negedge clock);
		requireAck(lookupAck, 1'b1, "paired lookup was not acknowledged after the store");
		runLookupChecks(id);
		@(posedge clock);
		lookupReq <= 1'b0;
		@(negedge clock);
		requireAck(lookupAck, 1'b0, "lookup acknowledge lasted longer than one cycle");
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		stimRow_t row;
		int       gap;
		clock     = 1'b0;
		reset     = 1'b1;
		storeReq  = 1'b0;
		storeData = '0;
		lookupReq = 1'b0;
		lookupId  = '0;
		seed      = 32'h5c1e_0569;
		mUsed     = '0;
		for (int i = 0; i < TableEntries; i++) begin
			mValid[i] = 1'b0;
			mId[i]    = '0;
			mAddr[i]  = '0;
			mLen[i]   = '0;
		end
		repeat (ResetCycles) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		requireAck(storeAck, 1'b0, "store acknowledge is high after reset");
		requireAck(lookupAck, 1'b0, "lookup acknowledge is high after reset");
		checkUsed(usedSize, '0);
		checkFull(full, 1'b0);
		checkLookup(lookupResult, '0);
		for (int n = 0; n < NumRows; n++) begin
			row = Rows[n];
			gap = $random(seed) & 3;	// Zero to three idle cycles
			repeat (gap) @(negedge clock);
			checkFull(full, row.expectFull);
			if (modelFull() != row.expectFull) begin
				abortRun($sformatf("stimulus row %0d disagrees with the reference model on full", n));
			end
			case (row.op)
				opStore:  runStore(row.storeId, row.length);
				opLookup: runLookup(row.lookupId);
				default: begin
					if (modelFull()) begin
						runHeldPair(row.storeId, row.length, row.lookupId);
					end else begin
						runPair(row.storeId, row.length, row.lookupId);
					end
				end
			endcase
		end
		$display("Simulation completed successfully");
		$finish;
	end

	// Watchdog
	initial begin
		#(TimeoutCycles * ClockPeriod);
		abortRun("timeout: the test rows did not finish in the expected number of cycles");
	end

endmodule

// ==== verilog/mapControl.sv ====
// One transaction at a time, stores first; requests must stay stable until their ack
module mapControl
	import progMapPkg::*;
(
	input  logic clock,
	input  logic reset,
	input  logic storeReq,
	input  logic lookupReq,
	input  logic slotFree,
	input  logic atCapacity,
	output logic storeWrite,
	output logic lookupTake,
	output logic storeAck,
	output logic lookupAck,
	output logic full
);

	mapState_e state;
	mapState_e nextState;

	assign full = ~slotFree | atCapacity;

	//////////////////////////////
	// Strobes out of idle
	//////////////////////////////

	assign storeWrite = (state == mapIdle) && storeReq && !full;
	assign lookupTake = (state == mapIdle) && lookupReq && !storeWrite;	// Store wins

	always_comb begin
		nextState = state;
		case (state)
			mapIdle: begin
				if (storeWrite) begin
					nextState = mapStoreAck;
				end else if (lookupTake) begin
					nextState = mapLookupAck;
				end
			end
			mapStoreAck:  nextState = mapIdle;
			mapLookupAck: nextState = mapIdle;
			default:      nextState = mapIdle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= mapIdle;
		end else begin
			state <= nextState;
		end
	end

	assign storeAck  = state == mapStoreAck;
	assign lookupAck = state == mapLookupAck;

	// Requesters hold their request through the acknowledge pulse
	assert property (@(posedge clock) disable iff (reset)
		storeAck |-> storeReq);

	assert property (@(posedge clock) disable iff (reset)
		lookupAck |-> lookupReq);

endmodule

// ==== verilog/mapTable.sv ====
// Eight-slot program map; a store and a take never arrive in the same cycle, no duplicate-ID check
module mapTable
	import progMapPkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  logic          storeWrite,
	input  logic          lookupTake,
	input  storeRequest_t storeData,
	input  memWord_t      baseAddress,	// Current used size
	input  threadId_t     lookupId,
	output logic          slotFree,
	output logic          hitNow,
	output memWord_t      removedLength,
	output lookupResult_t lookupResult
);

	mapEntry_t              entries [TableEntries];
	logic [TableEntries-1:0] freeVec;
	logic [TableEntries-1:0] matchVec;
	tableIndex_t            freeIndex;
	tableIndex_t            matchIndex;

	//////////////////////////////
	// Match and free vectors
	//////////////////////////////

	always_comb begin
		for (int i = 0; i < TableEntries; i++) begin
			freeVec[i]  = ~entries[i].valid;
			matchVec[i] = entries[i].valid && (entries[i].threadId == lookupId);
		end
	end

	slotEncoder #(
		.Entries (TableEntries)
	) freeFinder (
		.bits  (freeVec),
		.index (freeIndex),
		.any   (slotFree)
	);

	slotEncoder #(
		.Entries (TableEntries)
	) matchFinder (
		.bits  (matchVec),
		.index (matchIndex),
		.any   (hitNow)
	);

	assign removedLength = entries[matchIndex].length;	// Only meaningful with hitNow

	//////////////////////////////
	// Table registers
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < TableEntries; i++) begin
				entries[i].valid <= 1'b0;
			end
		end else begin
			if (storeWrite) begin
				entries[freeIndex].valid    <= 1'b1;
				entries[freeIndex].threadId <= storeData.threadId;
				entries[freeIndex].address  <= baseAddress;	// Bump allocation
				entries[freeIndex].length   <= storeData.length;
			end
			if (lookupTake && hitNow) begin
				entries[matchIndex].valid <= 1'b0;	// Free on dispatch
			end
		end
	end

	// Result held until the next lookup
	always_ff @(posedge clock) begin
		if (reset) begin
			lookupResult <= '0;
		end else if (lookupTake) begin
			lookupResult.hit     <= hitNow;
			lookupResult.address <= hitNow ? entries[matchIndex].address : '0;
			lookupResult.length  <= hitNow ? removedLength : '0;
		end
	end

	// Control must hold stores back while the table is full
	assert property (@(posedge clock) disable iff (reset)
		storeWrite |-> !entries[freeIndex].valid);

endmodule

// ==== verilog/progMapPkg.sv ====
// Shared sizes and types; the table depth must stay a power of two matching TableIndexWidth
package progMapPkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////

	localparam int TableEntries    = 8;
	localparam int TableIndexWidth = 3;
	localparam int ThreadIdWidth   = 6;
	localparam int AddressWidth    = 10;
	localparam int MemWords        = 1024;	// Instruction-memory words

	typedef logic [ThreadIdWidth-1:0]   threadId_t;
	typedef logic [AddressWidth-1:0]    memWord_t;	// Address or length
	typedef logic [TableIndexWidth-1:0] tableIndex_t;

	//////////////////////////////
	// Payloads
	//////////////////////////////

	// Loader request, 16 bits
	typedef struct packed {
		threadId_t threadId;
		memWord_t  length;
	} storeRequest_t;

	// One map-table entry, 27 bits
	typedef struct packed {
		logic      valid;
		threadId_t threadId;
		memWord_t  address;	// Start word in instruction memory
		memWord_t  length;
	} mapEntry_t;

	// Answer to the dispatcher, 21 bits
	typedef struct packed {
		logic     hit;
		memWord_t address;
		memWord_t length;
	} lookupResult_t;

	typedef enum logic [1:0] {
		mapIdle,
		mapStoreAck,
		mapLookupAck
	} mapState_e;

endpackage

// ==== verilog/programMapper.sv ====
// Program-map top; no memory compaction, addresses reused safely only for in-order release
module programMapper
	import progMapPkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  logic          storeReq,
	input  storeRequest_t storeData,
	output logic          storeAck,
	input  logic          lookupReq,
	input  threadId_t     lookupId,
	output logic          lookupAck,
	output lookupResult_t lookupResult,
	output memWord_t      usedSize,
	output logic          full
);

	logic     storeWrite;
	logic     lookupTake;
	logic     slotFree;
	logic     atCapacity;
	logic     hitNow;
	logic     subEnable;
	memWord_t removedLength;

	assign subEnable = lookupTake & hitNow;	// Misses leave the size alone

	mapControl i_mapControl (
		.clock      (clock),
		.reset      (reset),
		.storeReq   (storeReq),
		.lookupReq  (lookupReq),
		.slotFree   (slotFree),
		.atCapacity (atCapacity),
		.storeWrite (storeWrite),
		.lookupTake (lookupTake),
		.storeAck   (storeAck),
		.lookupAck  (lookupAck),
		.full       (full)
	);

	mapTable i_mapTable (
		.clock         (clock),
		.reset         (reset),
		.storeWrite    (storeWrite),
		.lookupTake    (lookupTake),
		.storeData     (storeData),
		.baseAddress   (usedSize),
		.lookupId      (lookupId),
		.slotFree      (slotFree),
		.hitNow        (hitNow),
		.removedLength (removedLength),
		.lookupResult  (lookupResult)
	);

	usedSizeTracker i_usedSizeTracker (
		.clock      (clock),
		.reset      (reset),
		.addEnable  (storeWrite),
		.addLength  (storeData.length),
		.subEnable  (subEnable),
		.subLength  (removedLength),
		.usedSize   (usedSize),
		.atCapacity (atCapacity)
	);

endmodule

// ==== verilog/slotEncoder.sv ====
// Lowest-index priority encoder; Entries must not exceed the range of tableIndex_t
module slotEncoder
	import progMapPkg::*;
#(
	parameter int Entries = 8
) (
	input  logic [Entries-1:0] bits,
	output tableIndex_t        index,
	output logic               any
);

	assign any = |bits;

	// Scan from the top so the lowest set bit is the last one taken
	always_comb begin
		index = '0;
		for (int i = Entries - 1; i >= 0; i--) begin
			if (bits[i]) begin
				index = tableIndex_t'(i);
			end
		end
	end

endmodule

// ==== verilog/usedSizeTracker.sv ====
// Used-word counter; no overflow guard, the store gate relies on atCapacity and slot count
module usedSizeTracker
	import progMapPkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     addEnable,
	input  memWord_t addLength,
	input  logic     subEnable,
	input  memWord_t subLength,
	output memWord_t usedSize,
	output logic     atCapacity
);

	memWord_t count;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (addEnable) begin
			count <= count + addLength;	// Store placed
		end else if (subEnable) begin
			count <= count - subLength;	// Program dispatched
		end
	end

	assign usedSize   = count;
	assign atCapacity = count >= memWord_t'(MemWords - 1);	// Last word reached

	// Releases only give back what stores added
	assert property (@(posedge clock) disable iff (reset)
		subEnable |-> subLength <= count);

	// Control serializes stores and lookups
	assert property (@(posedge clock) disable iff (reset)
		!(addEnable && subEnable));

endmodule
